// File: include/l1_settings.svh
`ifndef L1_SETTINGS_SVH
`define L1_SETTINGS_SVH

// L1 data cache geometry
`define L1_NUM_WAYS     2
`define L1_NUM_SETS     16
`define L1_LINE_BYTES   16

// Physical address split into tag, set and byte offset
`define PADDR_BITS      16
`define L1_OFFSET_BITS  4
`define L1_SET_BITS     4
`define L1_TAG_BITS     8

// Core-side identifiers
`define ROBID_BITS      5
`define PREG_BITS       6

// MM0 through MM5
`define NUM_MM_STAGES   6

`endif

// File: design/mem_pkg.sv
`include "l1_settings.svh"

package mem_pkg;

    typedef logic [`PADDR_BITS-1:0]             t_paddr;
    typedef logic [`L1_TAG_BITS-1:0]            t_l1_tag;
    typedef logic [`L1_SET_BITS-1:0]            t_l1_set_addr;
    typedef logic [$clog2(`L1_NUM_WAYS)-1:0]    t_l1_way;
    typedef logic [`L1_OFFSET_BITS-1:0]         t_cl_offset;
    typedef logic [`L1_LINE_BYTES*8-1:0]        t_cl;
    typedef logic [31:0]                        t_reg_data;
    typedef logic [`ROBID_BITS-1:0]             t_robid;
    typedef logic [`PREG_BITS-1:0]              t_preg;

    typedef enum logic [1:0] {
        MEM_LOAD  = 2'd0,
        MEM_STORE = 2'd1,
        MEM_FILL  = 2'd2
    } t_mem_op;

    typedef enum logic [1:0] {
        MESI_I = 2'd0,
        MESI_S = 2'd1,
        MESI_E = 2'd2,
        MESI_M = 2'd3
    } t_mesi;

    // Fill fields are only meaningful for MEM_FILL
    typedef struct packed {
        t_mem_op    op;
        t_paddr     addr;
        t_robid     robid;
        t_preg      pdst;
        t_l1_way    fill_way;
        t_mesi      fill_state;
        t_cl        fill_data;
    } t_mempipe_arb;

    typedef struct packed {
        logic complete;
        logic recycle;
    } t_mempipe_action;

    typedef struct packed {
        logic   valid;
        t_robid robid;
    } t_rob_complete_pkt;

    typedef struct packed {
        t_preg      pdst;
        t_reg_data  data;
    } t_prf_wr_pkt;

endpackage

// File: design/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
    import mem_pkg::*;
(
    input  logic            clk,
    input  logic            rst,

    input  logic            ld_req,
    input  t_mempipe_arb    ld_pkt,
    output logic            ld_gnt,

    input  logic            st_req,
    input  t_mempipe_arb    st_pkt,
    output logic            st_gnt,

    input  logic            fl_req,
    input  t_mempipe_arb    fl_pkt,
    output logic            fl_gnt,

    output logic            valid_mm0,
    output t_mempipe_arb    req_pkt_mm0
);

    // Fixed priority of load over store over fill
    assign ld_gnt = ld_req;
    assign st_gnt = st_req & ~ld_req;
    assign fl_gnt = fl_req & ~ld_req & ~st_req;

    assign valid_mm0 = ld_req | st_req | fl_req;

    always_comb begin
        if (ld_req) begin
            req_pkt_mm0 = ld_pkt;
        end else if (st_req) begin
            req_pkt_mm0 = st_pkt;
        end else begin
            req_pkt_mm0 = fl_pkt;
        end
    end

endmodule

// File: design/l1_tag_array.sv
`timescale 1ns/1ps
`include "l1_settings.svh"

module l1_tag_array
    import mem_pkg::*;
(
    input  logic            clk,
    input  logic            rst,

    input  logic            rd_en,
    input  logic            wr_en,
    input  t_l1_set_addr    set_addr,
    input  t_l1_way         wr_way,
    input  t_l1_tag         wr_tag,
    input  t_mesi           wr_state,

    output t_l1_tag         tag_rd_ways   [`L1_NUM_WAYS-1:0],
    output t_mesi           state_rd_ways [`L1_NUM_WAYS-1:0]
);

    t_l1_tag    tag_mem   [`L1_NUM_SETS][`L1_NUM_WAYS];
    t_mesi      state_mem [`L1_NUM_SETS][`L1_NUM_WAYS];

    // Fill writes the tag of one way
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[set_addr][wr_way] <= wr_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `L1_NUM_SETS; s++) begin
                for (int w = 0; w < `L1_NUM_WAYS; w++) begin
                    state_mem[s][w] <= MESI_I;
                end
            end
        end else if (wr_en) begin
            state_mem[set_addr][wr_way] <= wr_state;
        end
    end

    // Whole set read out with one entry per way
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < `L1_NUM_WAYS; w++) begin
                tag_rd_ways[w]   <= tag_mem[set_addr][w];
                state_rd_ways[w] <= state_mem[set_addr][w];
            end
        end
    end

endmodule

// File: design/l1_data_array.sv
`timescale 1ns/1ps
`include "l1_settings.svh"

module l1_data_array
    import mem_pkg::*;
(
    input  logic            clk,

    input  logic            rd_en,
    input  logic            wr_en,
    input  t_l1_set_addr    set_addr,
    input  t_l1_way         wr_way,
    input  t_cl             wr_data,

    output t_cl             data_rd_ways [`L1_NUM_WAYS-1:0]
);

    t_cl line_mem [`L1_NUM_SETS][`L1_NUM_WAYS];

    // Fill writes a full line into one way
    always_ff @(posedge clk) begin
        if (wr_en) begin
            line_mem[set_addr][wr_way] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < `L1_NUM_WAYS; w++) begin
                data_rd_ways[w] <= line_mem[set_addr][w];
            end
        end
    end

endmodule

// File: design/mempipe.sv
`timescale 1ns/1ps
`include "l1_settings.svh"

module mempipe
    import mem_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    input  logic                valid_mm0,
    input  t_mempipe_arb        req_pkt_mm0,

    output t_l1_set_addr        set_addr_mm1,
    output logic                tag_rd_en_mm1,
    output logic                tag_wr_en_mm1,
    output t_l1_way             tag_wr_way_mm1,
    output t_l1_tag             tag_wr_tag_mm1,
    output t_mesi               state_wr_mm1,
    output t_cl                 data_wr_mm1,

    input  t_l1_tag             tag_rd_ways_mm2   [`L1_NUM_WAYS-1:0],
    input  t_mesi               state_rd_ways_mm2 [`L1_NUM_WAYS-1:0],
    input  t_cl                 data_rd_ways_mm2  [`L1_NUM_WAYS-1:0],

    output logic                valid_mm5,
    output t_mempipe_action     action_mm5,
    output t_rob_complete_pkt   complete_mm5,
    output logic                iprf_wr_en_mm5,
    output t_prf_wr_pkt         iprf_wr_pkt_mm5
);

    // Stage registers where index n holds the MMn copy
    logic                       valid_mmx   [1:`NUM_MM_STAGES-1];
    t_mempipe_arb               req_pkt_mmx [1:`NUM_MM_STAGES-1];

    logic [`L1_NUM_WAYS-1:0]    hit_vec_mm2;
    logic [`L1_NUM_WAYS-1:0]    hit_vec_mm3;
    t_cl                        data_set_mm3 [`L1_NUM_WAYS-1:0];
    t_cl                        line_mm3;
    t_cl                        line_mm4;
    logic                       hit_mm4;
    t_reg_data                  rot_mm4;
    t_reg_data                  rot_mm5;
    logic                       hit_mm5;
    t_l1_tag                    tag_mm2;
    logic                       is_ld_mm2;
    logic                       is_st_mm2;
    logic                       is_ld_mm5;
    logic                       is_st_mm5;
    logic                       is_fl_mm5;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 1; s < `NUM_MM_STAGES; s++) begin
                valid_mmx[s] <= 1'b0;
            end
        end else begin
            valid_mmx[1] <= valid_mm0;
            for (int s = 2; s < `NUM_MM_STAGES; s++) begin
                valid_mmx[s] <= valid_mmx[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        req_pkt_mmx[1] <= req_pkt_mm0;
        for (int s = 2; s < `NUM_MM_STAGES; s++) begin
            req_pkt_mmx[s] <= req_pkt_mmx[s-1];
        end
    end

    // MM1 array access where fills write and loads and stores read
    assign set_addr_mm1   = req_pkt_mmx[1].addr[`L1_OFFSET_BITS +: `L1_SET_BITS];
    assign tag_rd_en_mm1  = valid_mmx[1] & (req_pkt_mmx[1].op inside {MEM_LOAD, MEM_STORE});
    assign tag_wr_en_mm1  = valid_mmx[1] & (req_pkt_mmx[1].op == MEM_FILL);
    assign tag_wr_way_mm1 = req_pkt_mmx[1].fill_way;
    assign tag_wr_tag_mm1 = req_pkt_mmx[1].addr[`PADDR_BITS-1 -: `L1_TAG_BITS];
    assign state_wr_mm1   = req_pkt_mmx[1].fill_state;
    assign data_wr_mm1    = req_pkt_mmx[1].fill_data;

    // MM2 hit detection per way
    assign tag_mm2   = req_pkt_mmx[2].addr[`PADDR_BITS-1 -: `L1_TAG_BITS];
    assign is_ld_mm2 = req_pkt_mmx[2].op == MEM_LOAD;
    assign is_st_mm2 = req_pkt_mmx[2].op == MEM_STORE;

    for (genvar w = 0; w < `L1_NUM_WAYS; w++) begin : g_hit
        // Stores need ownership while loads accept any valid copy
        assign hit_vec_mm2[w] = valid_mmx[2]
            & (tag_rd_ways_mm2[w] == tag_mm2)
            & ((is_ld_mm2 & (state_rd_ways_mm2[w] inside {MESI_S, MESI_E, MESI_M}))
             | (is_st_mm2 & (state_rd_ways_mm2[w] inside {MESI_E, MESI_M})));
    end

    always_ff @(posedge clk) begin
        hit_vec_mm3  <= hit_vec_mm2;
        data_set_mm3 <= data_rd_ways_mm2;
    end

    // MM3 AND-OR way select over a one-hot or zero hit vector
    always_comb begin
        line_mm3 = '0;
        for (int w = 0; w < `L1_NUM_WAYS; w++) begin
            line_mm3 = line_mm3 | (data_set_mm3[w] & {$bits(t_cl){hit_vec_mm3[w]}});
        end
    end

    always_ff @(posedge clk) begin
        line_mm4 <= line_mm3;
        hit_mm4  <= |hit_vec_mm3;
    end

    // MM4 byte rotate with the offset wrapping within the line
    always_comb begin
        t_cl_offset o;
        o = req_pkt_mmx[4].addr[`L1_OFFSET_BITS-1:0];
        for (int b = 0; b < 4; b++) begin
            rot_mm4[8*b +: 8] = line_mm4[8*o +: 8];
            o = o + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        rot_mm5 <= rot_mm4;
        hit_mm5 <= hit_mm4;
    end

    // MM5 result
    assign is_ld_mm5 = req_pkt_mmx[5].op == MEM_LOAD;
    assign is_st_mm5 = req_pkt_mmx[5].op == MEM_STORE;
    assign is_fl_mm5 = req_pkt_mmx[5].op == MEM_FILL;

    assign valid_mm5 = valid_mmx[5];

    always_comb begin
        action_mm5.complete = valid_mmx[5] & (((is_ld_mm5 | is_st_mm5) & hit_mm5) | is_fl_mm5);
        action_mm5.recycle  = valid_mmx[5] & (is_ld_mm5 | is_st_mm5) & ~hit_mm5;

        complete_mm5.valid  = valid_mmx[5] & (is_ld_mm5 | is_st_mm5) & hit_mm5;
        complete_mm5.robid  = req_pkt_mmx[5].robid;

        iprf_wr_en_mm5       = valid_mmx[5] & is_ld_mm5 & hit_mm5;
        iprf_wr_pkt_mm5.pdst = req_pkt_mmx[5].pdst;
        iprf_wr_pkt_mm5.data = rot_mm5;
    end

endmodule

// File: design/l1_cache_top.sv
`timescale 1ns/1ps
`include "l1_settings.svh"

module l1_cache_top
    import mem_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    input  logic                ld_req,
    input  t_mempipe_arb        ld_pkt,
    output logic                ld_gnt,

    input  logic                st_req,
    input  t_mempipe_arb        st_pkt,
    output logic                st_gnt,

    input  logic                fl_req,
    input  t_mempipe_arb        fl_pkt,
    output logic                fl_gnt,

    output logic                valid_mm5,
    output t_mempipe_action     action_mm5,
    output t_rob_complete_pkt   complete_mm5,
    output logic                iprf_wr_en_mm5,
    output t_prf_wr_pkt         iprf_wr_pkt_mm5
);

    logic           valid_mm0;
    t_mempipe_arb   req_pkt_mm0;

    t_l1_set_addr   set_addr_mm1;
    logic           tag_rd_en_mm1;
    logic           tag_wr_en_mm1;
    t_l1_way        tag_wr_way_mm1;
    t_l1_tag        tag_wr_tag_mm1;
    t_mesi          state_wr_mm1;
    t_cl            data_wr_mm1;

    t_l1_tag        tag_rd_ways_mm2   [`L1_NUM_WAYS-1:0];
    t_mesi          state_rd_ways_mm2 [`L1_NUM_WAYS-1:0];
    t_cl            data_rd_ways_mm2  [`L1_NUM_WAYS-1:0];

    mem_arbiter arb (
        .clk,
        .rst,
        .ld_req,
        .ld_pkt,
        .ld_gnt,
        .st_req,
        .st_pkt,
        .st_gnt,
        .fl_req,
        .fl_pkt,
        .fl_gnt,
        .valid_mm0,
        .req_pkt_mm0
    );

    mempipe pipe (
        .clk,
        .rst,
        .valid_mm0,
        .req_pkt_mm0,
        .set_addr_mm1,
        .tag_rd_en_mm1,
        .tag_wr_en_mm1,
        .tag_wr_way_mm1,
        .tag_wr_tag_mm1,
        .state_wr_mm1,
        .data_wr_mm1,
        .tag_rd_ways_mm2,
        .state_rd_ways_mm2,
        .data_rd_ways_mm2,
        .valid_mm5,
        .action_mm5,
        .complete_mm5,
        .iprf_wr_en_mm5,
        .iprf_wr_pkt_mm5
    );

    // Tag, state and data arrays share the MM1 set address and enables
    l1_tag_array tags (
        .clk,
        .rst,
        .rd_en          (tag_rd_en_mm1),
        .wr_en          (tag_wr_en_mm1),
        .set_addr       (set_addr_mm1),
        .wr_way         (tag_wr_way_mm1),
        .wr_tag         (tag_wr_tag_mm1),
        .wr_state       (state_wr_mm1),
        .tag_rd_ways    (tag_rd_ways_mm2),
        .state_rd_ways  (state_rd_ways_mm2)
    );

    l1_data_array data (
        .clk,
        .rd_en          (tag_rd_en_mm1),
        .wr_en          (tag_wr_en_mm1),
        .set_addr       (set_addr_mm1),
        .wr_way         (tag_wr_way_mm1),
        .wr_data        (data_wr_mm1),
        .data_rd_ways   (data_rd_ways_mm2)
    );

endmodule

// File: tests/l1_cache_asserts.sv
`timescale 1ns/1ps

module l1_cache_asserts
    import mem_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                ld_gnt,
    input  logic                st_gnt,
    input  logic                fl_gnt,
    input  t_mempipe_action     action_mm5,
    input  logic                iprf_wr_en_mm5
);

    // Fixed priority means a single winner per cycle
    a_one_gnt: assert property (@(posedge clk) disable iff (rst)
        $onehot0({ld_gnt, st_gnt, fl_gnt}))
        else $error("More than one grant high in the same cycle");

    // Register writes only come from completing loads
    a_wr_needs_complete: assert property (@(posedge clk) disable iff (rst)
        iprf_wr_en_mm5 |-> action_mm5.complete)
        else $error("Register write without a completion");

    a_complete_or_recycle: assert property (@(posedge clk) disable iff (rst)
        !(action_mm5.complete && action_mm5.recycle))
        else $error("Complete and recycle high together");

endmodule

// File: tests/tb_l1_cache.sv
`timescale 1ns/1ps
`include "l1_settings.svh"

module tb_l1_cache
    import mem_pkg::*;
();

    typedef struct packed {
        logic [1:0] winner;
        logic       complete;
        logic       recycle;
        t_robid     robid;
        logic       wr_en;
        t_preg      pdst;
        t_reg_data  data;
    } t_expect;

    logic                   clk;
    logic                   rst;
    logic                   ld_req;
    logic                   st_req;
    logic                   fl_req;
    t_mempipe_arb           ld_pkt;
    t_mempipe_arb           st_pkt;
    t_mempipe_arb           fl_pkt;
    logic                   ld_gnt;
    logic                   st_gnt;
    logic                   fl_gnt;
    logic                   valid_mm5;
    t_mempipe_action        action_mm5;
    t_rob_complete_pkt      complete_mm5;
    logic                   iprf_wr_en_mm5;
    t_prf_wr_pkt            iprf_wr_pkt_mm5;

    // Rows read from the case file
    logic                   grp_q [$];
    logic [2:0]             req_q [$];
    t_mempipe_arb           ld_q [$];
    t_mempipe_arb           st_q [$];
    t_mempipe_arb           fl_q [$];
    t_expect                exp_q [$];

    // Accepted requests waiting for their MM5 result
    t_expect                pend_q [$];
    int                     due_q [$];

    t_expect                cur_exp;
    logic                   cur_active;
    logic                   rows_loaded;
    logic [15:0]            lfsr;
    int                     row_count;
    int                     ncyc;
    int                     checks;
    int                     mismatches;
    int                     other_errors;
    bit                     load_ok;

    l1_cache_top dut (
        .clk            (clk),
        .rst            (rst),
        .ld_req         (ld_req),
        .ld_pkt         (ld_pkt),
        .ld_gnt         (ld_gnt),
        .st_req         (st_req),
        .st_pkt         (st_pkt),
        .st_gnt         (st_gnt),
        .fl_req         (fl_req),
        .fl_pkt         (fl_pkt),
        .fl_gnt         (fl_gnt),
        .valid_mm5      (valid_mm5),
        .action_mm5     (action_mm5),
        .complete_mm5   (complete_mm5),
        .iprf_wr_en_mm5 (iprf_wr_en_mm5),
        .iprf_wr_pkt_mm5(iprf_wr_pkt_mm5)
    );

    bind l1_cache_top l1_cache_asserts chk (
        .clk            (clk),
        .rst            (rst),
        .ld_gnt         (ld_gnt),
        .st_gnt         (st_gnt),
        .fl_gnt         (fl_gnt),
        .action_mm5     (action_mm5),
        .iprf_wr_en_mm5 (iprf_wr_en_mm5)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int idle_cycles();
        int n;
        n = 0;
        for (int b = 0; b < 2; b++) begin
            n = n | (int'(lfsr[0]) << b);
            lfsr = lfsr_step(lfsr);
        end
        return n;
    endfunction

    function automatic logic [2:0] grant_for_winner(input logic [1:0] win);
        case (win)
            2'd0:    return 3'b100;
            2'd1:    return 3'b010;
            default: return 3'b001;
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        mismatches++;
    endtask

    task automatic load_cases(output bit ok);
        int             fd;
        int             n;
        string          line;
        t_mempipe_arb   pkt;
        t_expect        e;
        logic [3:0]     f_grp;
        logic [3:0]     f_ld;
        logic [3:0]     f_st;
        logic [3:0]     f_fl;
        t_paddr         f_ld_addr;
        t_robid         f_ld_rob;
        t_preg          f_ld_pdst;
        t_paddr         f_st_addr;
        t_robid         f_st_rob;
        t_paddr         f_fl_addr;
        logic [3:0]     f_fl_way;
        logic [3:0]     f_fl_st;
        t_cl            f_fl_data;
        logic [3:0]     f_win;
        logic [3:0]     f_cmp;
        logic [3:0]     f_rcy;
        t_robid         f_rob;
        logic [3:0]     f_wr;
        t_preg          f_pdst;
        t_reg_data      f_data;
        ok = 1'b0;
        fd = $fopen("tests/l1_cache_cases.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f_grp, f_ld, f_st, f_fl, f_ld_addr, f_ld_rob, f_ld_pdst,
                        f_st_addr, f_st_rob, f_fl_addr, f_fl_way, f_fl_st, f_fl_data,
                        f_win, f_cmp, f_rcy, f_rob, f_wr, f_pdst, f_data);
                    if (n == 20) begin
                        pkt = '0;
                        pkt.op = MEM_LOAD;
                        pkt.addr = f_ld_addr;
                        pkt.robid = f_ld_rob;
                        pkt.pdst = f_ld_pdst;
                        ld_q.push_back(pkt);
                        pkt = '0;
                        pkt.op = MEM_STORE;
                        pkt.addr = f_st_addr;
                        pkt.robid = f_st_rob;
                        st_q.push_back(pkt);
                        pkt = '0;
                        pkt.op = MEM_FILL;
                        pkt.addr = f_fl_addr;
                        pkt.fill_way = f_fl_way[0:0];
                        pkt.fill_state = t_mesi'(f_fl_st[1:0]);
                        pkt.fill_data = f_fl_data;
                        fl_q.push_back(pkt);
                        grp_q.push_back(f_grp[0]);
                        req_q.push_back({f_ld[0], f_st[0], f_fl[0]});
                        e.winner = f_win[1:0];
                        e.complete = f_cmp[0];
                        e.recycle = f_rcy[0];
                        e.robid = f_rob;
                        e.wr_en = f_wr[0];
                        e.pdst = f_pdst;
                        e.data = f_data;
                        exp_q.push_back(e);
                    end else begin
                        $display("Case file line could not be parsed: %s", line);
                        other_errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_idle();
        ld_req = 1'b0;
        st_req = 1'b0;
        fl_req = 1'b0;
        cur_active = 1'b0;
    endtask

    task automatic drive_row(input int i);
        ld_req = req_q[i][2];
        st_req = req_q[i][1];
        fl_req = req_q[i][0];
        ld_pkt = ld_q[i];
        st_pkt = st_q[i];
        fl_pkt = fl_q[i];
        cur_exp = exp_q[i];
        cur_active = 1'b1;
    endtask

    task automatic compare_result(input t_expect e);
        logic exp_cv;
        // Fills complete in the pipe but not towards the ROB
        exp_cv = e.complete & (e.winner != 2'd2);
        checks++;
        if (valid_mm5 !== 1'b1) begin
            report_mismatch("valid_mm5", 32'(valid_mm5), 32'd1);
        end
        if (action_mm5.complete !== e.complete) begin
            report_mismatch("action complete", 32'(action_mm5.complete), 32'(e.complete));
        end
        if (action_mm5.recycle !== e.recycle) begin
            report_mismatch("action recycle", 32'(action_mm5.recycle), 32'(e.recycle));
        end
        if (complete_mm5.valid !== exp_cv) begin
            report_mismatch("ROB complete valid", 32'(complete_mm5.valid), 32'(exp_cv));
        end
        if (exp_cv && complete_mm5.robid !== e.robid) begin
            report_mismatch("ROB complete robid", 32'(complete_mm5.robid), 32'(e.robid));
        end
        if (iprf_wr_en_mm5 !== e.wr_en) begin
            report_mismatch("iprf_wr_en", 32'(iprf_wr_en_mm5), 32'(e.wr_en));
        end
        if (e.wr_en && iprf_wr_pkt_mm5.pdst !== e.pdst) begin
            report_mismatch("iprf pdst", 32'(iprf_wr_pkt_mm5.pdst), 32'(e.pdst));
        end
        if (e.wr_en && iprf_wr_pkt_mm5.data !== e.data) begin
            report_mismatch("load data", iprf_wr_pkt_mm5.data, e.data);
        end
    endtask

    // Grants and MM5 outputs sampled at the falling edge
    always @(negedge clk) begin
        ncyc = ncyc + 1;
        if (!rst) begin
            if (cur_active) begin
                if ({ld_gnt, st_gnt, fl_gnt} !== grant_for_winner(cur_exp.winner)) begin
                    report_mismatch("grant vector", 32'({ld_gnt, st_gnt, fl_gnt}),
                                    32'(grant_for_winner(cur_exp.winner)));
                end else begin
                    pend_q.push_back(cur_exp);
                    due_q.push_back(ncyc + `NUM_MM_STAGES - 1);
                end
            end
            if (due_q.size() != 0 && due_q[0] == ncyc) begin
                compare_result(pend_q[0]);
                void'(pend_q.pop_front());
                void'(due_q.pop_front());
            end else if (valid_mm5 !== 1'b0) begin
                report_mismatch("valid_mm5 with nothing due", 32'(valid_mm5), 32'd0);
            end
        end
    end

    initial begin
        rst = 1'b1;
        ld_pkt = '0;
        st_pkt = '0;
        fl_pkt = '0;
        cur_exp = '0;
        drive_idle();
        rows_loaded = 1'b0;
        lfsr = 16'd50959;
        ncyc = 0;
        checks = 0;
        mismatches = 0;
        other_errors = 0;
        load_cases(load_ok);
        row_count = exp_q.size();
        if (!load_ok) begin
            $display("Could not open the case file tests/l1_cache_cases.txt");
            $display("Simulation FAILED");
            $finish;
        end else begin
            rows_loaded = 1'b1;
            repeat (16) @(posedge clk);
            #1 rst = 1'b0;
            for (int i = 0; i < row_count; i++) begin
                // Rows that continue a case go back to back
                if (grp_q[i]) begin
                    repeat (idle_cycles()) begin
                        @(posedge clk);
                        #1 drive_idle();
                    end
                end
                @(posedge clk);
                #1 drive_row(i);
            end
            @(posedge clk);
            #1 drive_idle();
            while (pend_q.size() != 0) begin
                @(posedge clk);
            end
            repeat (2) @(posedge clk);
            if (checks != row_count) begin
                $display("Only %0d of %0d cases produced a result", checks, row_count);
                other_errors++;
            end
            $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                     checks, mismatches, other_errors);
            if (mismatches == 0 && other_errors == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

    initial begin
        wait (rows_loaded);
        repeat (row_count * 4 + 40) @(posedge clk);
        $display("Timeout, the run did not finish within %0d cycles", row_count * 4 + 40);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: tests/l1_cache_cases.txt
# grp ld st fl ld_addr ld_rob ld_pdst st_addr st_rob fl_addr fl_way fl_state fl_data (hex)
# expected: winner(0 ld 1 st 2 fl) complete recycle robid reg_wr pdst data (hex)
1 1 0 0 1230 01 01 0000 00 0000 0 0 00000000000000000000000000000000 0 0 1 01 0 01 00000000
1 0 0 1 0000 00 00 0000 00 4550 0 1 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 2 1 0 00 0 00 00000000
1 1 0 0 455e 04 0a 0000 00 0000 0 0 00000000000000000000000000000000 0 1 0 04 1 0a a1a0afae
1 1 0 0 4553 05 0b 0000 00 0000 0 0 00000000000000000000000000000000 0 1 0 05 1 0b a6a5a4a3
1 0 1 0 0000 00 00 4554 06 0000 0 0 00000000000000000000000000000000 1 0 1 06 0 00 00000000
1 1 0 0 5550 07 0c 0000 00 0000 0 0 00000000000000000000000000000000 0 0 1 07 0 0c 00000000
1 0 0 1 0000 00 00 0000 00 6670 1 2 bfbebdbcbbbab9b8b7b6b5b4b3b2b1b0 2 1 0 00 0 00 00000000
1 0 1 0 0000 00 00 6678 08 0000 0 0 00000000000000000000000000000000 1 1 0 08 0 00 00000000
1 0 0 1 0000 00 00 0000 00 7780 0 3 cfcecdcccbcac9c8c7c6c5c4c3c2c1c0 2 1 0 00 0 00 00000000
1 0 1 0 0000 00 00 7781 09 0000 0 0 00000000000000000000000000000000 1 1 0 09 0 00 00000000
1 1 1 1 7784 0a 0d 6670 0b 88a0 0 2 dfdedddcdbdad9d8d7d6d5d4d3d2d1d0 0 1 0 0a 1 0d c7c6c5c4
0 0 1 1 7784 0a 0d 6670 0b 88a0 0 2 dfdedddcdbdad9d8d7d6d5d4d3d2d1d0 1 1 0 0b 0 00 00000000
0 0 0 1 7784 0a 0d 6670 0b 88a0 0 2 dfdedddcdbdad9d8d7d6d5d4d3d2d1d0 2 1 0 00 0 00 00000000
1 1 0 0 88a8 0c 0e 0000 00 0000 0 0 00000000000000000000000000000000 0 1 0 0c 1 0e dbdad9d8
1 0 0 1 0000 00 00 0000 00 1190 0 1 efeeedecebeae9e8e7e6e5e4e3e2e1e0 2 1 0 00 0 00 00000000
1 0 0 1 0000 00 00 0000 00 2290 1 2 fffefdfcfbfaf9f8f7f6f5f4f3f2f1f0 2 1 0 00 0 00 00000000
1 1 0 0 1192 0d 0f 0000 00 0000 0 0 00000000000000000000000000000000 0 1 0 0d 1 0f e5e4e3e2
1 1 0 0 229c 0e 10 0000 00 0000 0 0 00000000000000000000000000000000 0 1 0 0e 1 10 fffefdfc
1 1 0 0 229f 10 12 0000 00 0000 0 0 00000000000000000000000000000000 0 1 0 10 1 12 f2f1f0ff
1 0 0 1 0000 00 00 0000 00 33b0 1 1 1f1e1d1c1b1a19181716151413121110 2 1 0 00 0 00 00000000
0 1 0 0 33bd 0f 11 0000 00 0000 0 0 00000000000000000000000000000000 0 1 0 0f 1 11 101f1e1d

// File: sim.f
+incdir+include
design/mem_pkg.sv
design/mem_arbiter.sv
design/l1_tag_array.sv
design/l1_data_array.sv
design/mempipe.sv
design/l1_cache_top.sv
tests/l1_cache_asserts.sv
tests/tb_l1_cache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the L1 cache testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_l1_cache -Mdir obj_dir \
    && ./obj_dir/Vtb_l1_cache | tee /dev/stderr | grep -qx "Simulation PASSED" \
    && echo "run_sim: pass message found" \
    || { echo "run_sim: pass message not found"; exit 1; }
